// File: sources.f
cache_pkg.sv
dp_ram.sv
line_ram.sv
cache.sv
backing_mem.sv
cache_top.sv
tb_cache_top.sv

// File: tb_cache_top.sv
// ============================================================================
// random-stimulus testbench for the cache and its backing memory, checked
// against a flat reference memory
// ============================================================================
`timescale 1ns/1ps

module tb_cache_top;

    import cache_pkg::*;

    logic                   clk;
    logic                   rst_n;
    logic                   enabled;
    logic [addr_bits-1:0]   c_addr;
    logic [data_bits-1:0]   c_data_in;
    logic [data_bits-1:0]   c_data_out;
    logic                   c_access;
    logic                   c_ack;
    logic                   c_wr_en;
    logic [data_bits/8-1:0] c_bytesel;

    // reference memory, one word per backing memory word
    logic [data_bits-1:0] ref_mem [mem_words];
    logic [31:0]          lcg_state;

    cache_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .enabled   (enabled),
        .c_addr    (c_addr),
        .c_data_in (c_data_in),
        .c_data_out(c_data_out),
        .c_access  (c_access),
        .c_ack     (c_ack),
        .c_wr_en   (c_wr_en),
        .c_bytesel (c_bytesel)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [addr_bits-1:0] make_addr(input int tag, input int index,
                                                       input int offset);
        return addr_bits'((tag << (offset_bits + index_bits)) | (index << offset_bits) | offset);
    endfunction

    // four tags on four indexes, so hits, misses and conflicts all occur
    function automatic logic [addr_bits-1:0] pick_addr();
        logic [31:0] r;
        r = next_rand();
        return make_addr(r[25:24], r[21:20], r[18:16]);
    endfunction

    function automatic logic [data_bits/8-1:0] pick_be();
        logic [31:0] r;
        r = next_rand();
        case (r[29:28])
            2'd1: return 2'b01;
            2'd2: return 2'b10;
            default: return 2'b11;
        endcase
    endfunction

    // sample edge, lookup edge, line transfers of latency plus ack, final lookup
    function automatic int miss_cycles(input int line_transfers);
        return 2 + line_transfers * line_words * (mem_latency + 1) + 1;
    endfunction

    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input logic [data_bits-1:0] got,
                              input logic [data_bits-1:0] exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            $display("error: c_ack latency got %h expected %h", got, exp);
            abort_run();
        end
    endtask

    // one frontend request; cycles counts rising edges until c_ack shows
    task automatic run_request(input logic [addr_bits-1:0] addr, input logic wr,
                               input logic [data_bits-1:0] wdata,
                               input logic [data_bits/8-1:0] be, output int cycles);
        logic [data_bits-1:0]     rdata;
        logic [mem_addr_bits-1:0] idx;
        bit                       acked;
        @(posedge clk);
        c_addr     <= addr;
        c_wr_en    <= wr;
        c_data_out <= wdata;
        c_bytesel  <= be;
        c_access   <= 1'b1;
        cycles = 0;
        acked  = 1'b0;
        rdata  = '0;
        // outputs settle after the rising edge, so look at the falling one
        while (!acked && cycles < 200) begin
            @(negedge clk);
            if (c_ack) begin
                acked = 1'b1;
                rdata = c_data_in;
            end else begin
                cycles++;
            end
        end
        if (!acked) begin
            $display("timeout: no c_ack within 200 cycles for address %h", addr);
            abort_run();
        end
        @(posedge clk);
        c_access <= 1'b0;
        idx = addr[mem_addr_bits-1:0];
        if (wr) begin
            for (int i = 0; i < data_bits / 8; i++) begin
                if (be[i]) begin
                    ref_mem[idx][i*8 +: 8] = wdata[i*8 +: 8];
                end
            end
        end else begin
            check_data("c_data_in", rdata, ref_mem[idx]);
        end
    endtask

    // only called with c_access already low
    task automatic set_enabled(input logic en);
        @(posedge clk);
        enabled <= en;
    endtask

    initial begin
        int                   lat;
        logic [31:0]          r;
        logic [addr_bits-1:0] a;
        logic [addr_bits-1:0] b;
        logic [addr_bits-1:0] bypass_addr [$];

        clk        = 1'b0;
        rst_n      = 1'b0;
        enabled    = 1'b1;
        c_addr     = '0;
        c_data_out = '0;
        c_access   = 1'b0;
        c_wr_en    = 1'b0;
        c_bytesel  = '0;
        lcg_state  = 32'hd2ba_90f4;

        for (int i = 0; i < mem_words; i++) begin
            r = next_rand();
            dut0.mem0.mem[i] = r[31:16];
            ref_mem[i] = r[31:16];
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // empty cache, so the first write is a clean miss and leaves the line dirty
        a = make_addr(1, 10, 3);
        b = make_addr(2, 10, 5);
        r = next_rand();
        run_request(a, 1'b1, r[31:16], 2'b11, lat);
        check_latency(lat, miss_cycles(1));
        // same index, other tag: write-back then fill
        run_request(b, 1'b0, '0, 2'b11, lat);
        check_latency(lat, miss_cycles(2));
        run_request(a, 1'b0, '0, 2'b11, lat);
        check_latency(lat, miss_cycles(1));
        run_request(a, 1'b0, '0, 2'b11, lat);
        check_latency(lat, 2);

        // random mix
        for (int n = 0; n < 400; n++) begin
            r = next_rand();
            run_request(pick_addr(), r[31], r[15:0], pick_be(), lat);
        end

        // a repeat read finds the line resident
        for (int n = 0; n < 20; n++) begin
            a = pick_addr();
            run_request(a, 1'b0, '0, 2'b11, lat);
            run_request(a, 1'b0, '0, 2'b11, lat);
            check_latency(lat, 2);
        end

        // one byte at a time
        for (int n = 0; n < 20; n++) begin
            a = pick_addr();
            r = next_rand();
            run_request(a, 1'b1, r[31:16], 2'b01, lat);
            run_request(a, 1'b0, '0, 2'b11, lat);
            run_request(a, 1'b1, r[15:0], 2'b10, lat);
            run_request(a, 1'b0, '0, 2'b11, lat);
        end

        // flush indexes 0 to 3 by conflicts before going around the cache
        for (int idx = 0; idx < 4; idx++) begin
            run_request(make_addr(9, idx, 0), 1'b0, '0, 2'b11, lat);
        end
        set_enabled(1'b0);
        for (int n = 0; n < 60; n++) begin
            a = pick_addr();
            r = next_rand();
            bypass_addr.push_back(a);
            run_request(a, r[31], r[15:0], pick_be(), lat);
        end
        set_enabled(1'b1);

        // words written in bypass come back through fills
        foreach (bypass_addr[k]) begin
            run_request(bypass_addr[k], 1'b0, '0, 2'b11, lat);
        end

        $display("Everything OK");
        $finish;
    end

endmodule

// File: cache_top.sv
// ============================================================================
// cache with its backing memory model, frontend bus at the boundary
// ============================================================================
`timescale 1ns/1ps

module cache_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              enabled,
    input  logic [cache_pkg::addr_bits-1:0]   c_addr,
    output logic [cache_pkg::data_bits-1:0]   c_data_in,
    input  logic [cache_pkg::data_bits-1:0]   c_data_out,
    input  logic                              c_access,
    output logic                              c_ack,
    input  logic                              c_wr_en,
    input  logic [cache_pkg::data_bits/8-1:0] c_bytesel
);

    import cache_pkg::*;

    // backend bus between cache and memory
    logic [addr_bits-1:0]   m_addr;
    logic [data_bits-1:0]   m_data_in;
    logic [data_bits-1:0]   m_data_out;
    logic                   m_access;
    logic                   m_ack;
    logic                   m_wr_en;
    logic [data_bits/8-1:0] m_bytesel;

    cache cache0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .enabled   (enabled),
        .c_addr    (c_addr),
        .c_data_in (c_data_in),
        .c_data_out(c_data_out),
        .c_access  (c_access),
        .c_ack     (c_ack),
        .c_wr_en   (c_wr_en),
        .c_bytesel (c_bytesel),
        .m_addr    (m_addr),
        .m_data_in (m_data_in),
        .m_data_out(m_data_out),
        .m_access  (m_access),
        .m_ack     (m_ack),
        .m_wr_en   (m_wr_en),
        .m_bytesel (m_bytesel)
    );

    backing_mem mem0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .m_addr    (m_addr),
        .m_data_out(m_data_out),
        .m_data_in (m_data_in),
        .m_access  (m_access),
        .m_ack     (m_ack),
        .m_wr_en   (m_wr_en),
        .m_bytesel (m_bytesel)
    );

endmodule

// File: backing_mem.sv
// ============================================================================
// word-addressed backing memory model with a fixed ack latency
// ============================================================================
`timescale 1ns/1ps

module backing_mem (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [cache_pkg::addr_bits-1:0]   m_addr,
    input  logic [cache_pkg::data_bits-1:0]   m_data_out,
    output logic [cache_pkg::data_bits-1:0]   m_data_in,
    input  logic                              m_access,
    output logic                              m_ack,
    input  logic                              m_wr_en,
    input  logic [cache_pkg::data_bits/8-1:0] m_bytesel
);

    import cache_pkg::*;

    // contents are preloaded from outside
    logic [data_bits-1:0] mem [mem_words];

    logic [$clog2(mem_latency + 1)-1:0] wait_cnt;
    logic [mem_addr_bits-1:0]           word_addr;
    logic                               respond;

    // upper address bits are not decoded
    assign word_addr = m_addr[mem_addr_bits-1:0];

    // last wait cycle before the ack edge
    assign respond = m_access && !m_ack && wait_cnt == mem_latency - 1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wait_cnt <= '0;
            m_ack    <= 1'b0;
        end else begin
            m_ack <= respond;
            if (respond) begin
                wait_cnt <= '0;
            end else if (m_access && !m_ack) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    // read and write both complete on the edge that raises m_ack
    always @(posedge clk) begin
        if (respond) begin
            m_data_in <= mem[word_addr];
            if (m_wr_en) begin
                for (int i = 0; i < data_bits / 8; i++) begin
                    if (m_bytesel[i]) begin
                        mem[word_addr][i*8 +: 8] <= m_data_out[i*8 +: 8];
                    end
                end
            end
        end
    end

    // address held from the first access cycle until the ack
    addr_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (m_access && $past(m_access) && !$past(m_ack)) |-> $stable(m_addr)
    );

endmodule

// File: cache.sv
// ============================================================================
// direct-mapped write-back cache controller: lookup, victim write-back,
// line fill and bypass mux
// ============================================================================
`timescale 1ns/1ps

module cache (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                enabled,
    // frontend
    input  logic [cache_pkg::addr_bits-1:0]     c_addr,
    output logic [cache_pkg::data_bits-1:0]     c_data_in,
    input  logic [cache_pkg::data_bits-1:0]     c_data_out,
    input  logic                                c_access,
    output logic                                c_ack,
    input  logic                                c_wr_en,
    input  logic [cache_pkg::data_bits/8-1:0]   c_bytesel,
    // backend
    output logic [cache_pkg::addr_bits-1:0]     m_addr,
    input  logic [cache_pkg::data_bits-1:0]     m_data_in,
    output logic [cache_pkg::data_bits-1:0]     m_data_out,
    output logic                                m_access,
    input  logic                                m_ack,
    output logic                                m_wr_en,
    output logic [cache_pkg::data_bits/8-1:0]   m_bytesel
);

    import cache_pkg::*;

    cache_state_e state;
    logic [addr_bits-1:0]   lat_addr;
    logic [offset_bits-1:0] wcnt;
    logic [num_lines-1:0]   valid;
    logic [num_lines-1:0]   dirty;
    logic                   ack_r;

    logic [index_bits-1:0]  lat_index;
    logic [tag_bits-1:0]    lat_tag;
    logic [index_bits-1:0]  tag_raddr;
    logic [tag_bits-1:0]    tag_q;
    logic [data_bits-1:0]   q_a;
    logic [data_bits-1:0]   q_b;
    logic [offset_bits-1:0] b_word;
    logic [addr_bits-1:0]   line_addr;

    logic start_req;
    logic hit;
    logic hit_write;
    logic last_word;
    logic start_fill;
    logic fill_write;
    logic busy;

    // fields of the latched request
    assign lat_index = lat_addr[offset_bits +: index_bits];
    assign lat_tag   = lat_addr[addr_bits-1 -: tag_bits];

    // a new request is ignored during its own ack cycle
    assign start_req = state == st_idle && enabled && c_access && !ack_r;

    assign hit       = valid[lat_index] && tag_q == lat_tag;
    assign hit_write = state == st_lookup && hit && c_wr_en;
    assign busy      = state == st_flush || state == st_fill;
    assign last_word = m_ack && wcnt == offset_bits'(line_words - 1);

    // clean miss or end of write-back, both start a fill
    assign start_fill = (state == st_lookup && !hit && !(valid[lat_index] && dirty[lat_index]))
                        || (state == st_flush && last_word);

    assign fill_write = state == st_fill && m_ack;

    // tags are read from the incoming address only when idle
    assign tag_raddr = state == st_idle ? c_addr[offset_bits +: index_bits] : lat_index;

    // during write-back, read one word ahead so q_b is ready for the next access
    assign b_word = (state == st_flush && m_ack) ? wcnt + 1'b1 : wcnt;

    // victim address from the stored tag, fill address from the request
    assign line_addr = state == st_flush ? {tag_q, lat_index, wcnt}
                                         : {lat_tag, lat_index, wcnt};

    // bypass mux
    assign c_ack      = enabled ? ack_r : m_ack;
    assign c_data_in  = enabled ? q_a : m_data_in;
    assign m_addr     = enabled ? line_addr : c_addr;
    assign m_data_out = enabled ? q_b : c_data_out;
    assign m_access   = enabled ? busy && !m_ack : c_access;
    assign m_wr_en    = enabled ? state == st_flush && !m_ack : c_wr_en;
    assign m_bytesel  = enabled ? {(data_bits/8){1'b1}} : c_bytesel;

    dp_ram #(
        .words(num_lines),
        .width(tag_bits)
    ) tag_ram (
        .clk  (clk),
        .raddr(tag_raddr),
        .q    (tag_q),
        .waddr(lat_index),
        .wr_en(start_fill),
        .wdata(lat_tag)
    );

    line_ram #(
        .words(num_lines * line_words),
        .width(data_bits)
    ) data_ram (
        .clk    (clk),
        .addr_a (lat_addr[index_bits+offset_bits-1:0]),
        .wr_en_a(hit_write),
        .be_a   (c_bytesel),
        .wdata_a(c_data_out),
        .q_a    (q_a),
        .addr_b ({lat_index, b_word}),
        .wr_en_b(fill_write),
        .wdata_b(m_data_in),
        .q_b    (q_b)
    );

    // request address, held for the whole transaction
    always_ff @(posedge clk) begin
        if (start_req) begin
            lat_addr <= c_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            ack_r <= 1'b0;
            wcnt  <= '0;
            valid <= '0;
            dirty <= '0;
        end else begin
            ack_r <= 1'b0;
            // wraps back to zero after the last word
            if (busy && m_ack) begin
                wcnt <= wcnt + 1'b1;
            end
            // line is invalid while its tag and data change
            if (start_fill) begin
                valid[lat_index] <= 1'b0;
            end
            case (state)
                st_idle: begin
                    if (start_req) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    if (hit) begin
                        ack_r <= 1'b1;
                        state <= st_idle;
                        if (hit_write) begin
                            dirty[lat_index] <= 1'b1;
                        end
                    end else if (start_fill) begin
                        state <= st_fill;
                    end else begin
                        state <= st_flush;
                    end
                end
                st_flush: begin
                    if (last_word) begin
                        dirty[lat_index] <= 1'b0;
                        state <= st_fill;
                    end
                end
                st_fill: begin
                    // retry the lookup, which now hits
                    if (last_word) begin
                        valid[lat_index] <= 1'b1;
                        state <= st_lookup;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // ack only answers a request that was pending
    ack_follows_access: assert property (
        @(posedge clk) disable iff (!rst_n) c_ack |-> $past(c_access)
    );

    // line transfers drop access only in the ack cycle
    backend_holds_access: assert property (
        @(posedge clk) disable iff (!rst_n) (enabled && $fell(m_access)) |-> m_ack
    );

    // enabled only toggles between requests
    idle_in_bypass: assert property (
        @(posedge clk) disable iff (!rst_n) !enabled |-> state == st_idle
    );

endmodule

// File: line_ram.sv
// ============================================================================
// true dual-port word RAM, byte enables on port a, whole words on port b
// ============================================================================
`timescale 1ns/1ps

module line_ram #(
    parameter int words = 512,
    parameter int width = 16
) (
    input  logic                     clk,
    // port a, frontend side
    input  logic [$clog2(words)-1:0] addr_a,
    input  logic                     wr_en_a,
    input  logic [width/8-1:0]       be_a,
    input  logic [width-1:0]         wdata_a,
    output logic [width-1:0]         q_a,
    // port b, fill and write-back side
    input  logic [$clog2(words)-1:0] addr_b,
    input  logic                     wr_en_b,
    input  logic [width-1:0]         wdata_b,
    output logic [width-1:0]         q_b
);

    logic [width-1:0] mem [words];

    // both ports in one process
    // the controller never writes both ports to one word in the same cycle
    always_ff @(posedge clk) begin
        if (wr_en_a) begin
            for (int i = 0; i < width / 8; i++) begin
                if (be_a[i]) begin
                    mem[addr_a][i*8 +: 8] <= wdata_a[i*8 +: 8];
                end
            end
        end
        if (wr_en_b) begin
            mem[addr_b] <= wdata_b;
        end
    end

    // registered reads, old data on a same-cycle write
    always_ff @(posedge clk) begin
        q_a <= mem[addr_a];
        q_b <= mem[addr_b];
    end

endmodule

// File: dp_ram.sv
// ============================================================================
// dual-port synchronous RAM, one read port and one write port
// ============================================================================
`timescale 1ns/1ps

module dp_ram #(
    parameter int words = 64,
    parameter int width = 10
) (
    input  logic                     clk,
    input  logic [$clog2(words)-1:0] raddr,
    output logic [width-1:0]         q,
    input  logic [$clog2(words)-1:0] waddr,
    input  logic                     wr_en,
    input  logic [width-1:0]         wdata
);

    logic [width-1:0] mem [words];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[waddr] <= wdata;
        end
    end

    // read port, registered
    // a read of the address being written returns the old word
    always_ff @(posedge clk) begin
        q <= mem[raddr];
    end

endmodule

// File: cache_pkg.sv
// ============================================================================
// geometry, backing memory latency and controller state type for the
// direct-mapped write-back cache
// ============================================================================
package cache_pkg;

    // word address and data
    localparam int addr_bits = 19;
    localparam int data_bits = 16;

    // line geometry
    localparam int line_words  = 8;
    localparam int offset_bits = 3;
    localparam int num_lines   = 64;
    localparam int index_bits  = 6;
    localparam int tag_bits    = addr_bits - index_bits - offset_bits;

    // backing memory model
    localparam int mem_words     = 8192;
    localparam int mem_addr_bits = 13;
    // cycles from first sampled access to ack
    localparam int mem_latency   = 3;

    // controller states
    // flush writes the victim back, fill reads the new line
    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_flush,
        st_fill
    } cache_state_e;

endpackage
